// ==== logic/ao_periph_cfg.svh ====
////////////////////////////////////////
// Always-on peripheral configuration
// Region map, register offsets, pin counts
////////////////////////////////////////
`ifndef AO_PERIPH_CFG_SVH
`define AO_PERIPH_CFG_SVH

`define AO_SOC_CTRL_BASE  32'h0000_0000
`define AO_FAST_INTR_BASE 32'h0000_1000
`define AO_GPIO_BASE      32'h0000_2000
`define AO_REGION_SIZE    32'h0000_1000
`define AO_ERR_WORD       32'hbadcab1e
`define AO_NUM_FAST_INTR  15
`define AO_NUM_GPIO       8

// SoC control offsets
`define SOC_EXIT_VALID    32'h0000_0000
`define SOC_EXIT_VALUE    32'h0000_0004
`define SOC_BOOT_SEL      32'h0000_0008
`define SOC_SCRATCH       32'h0000_000c

// Fast interrupt offsets
`define FIC_PENDING       32'h0000_0000
`define FIC_CLEAR         32'h0000_0004

// GPIO offsets
`define GPIO_OUT          32'h0000_0000
`define GPIO_EN           32'h0000_0004
`define GPIO_IN           32'h0000_0008
`define GPIO_INTR_EN      32'h0000_000c
`define GPIO_INTR_STATUS  32'h0000_0010

`endif

// ==== logic/ao_periph_pkg.sv ====
////////////////////////////////////////
// Always-on peripheral shared types
////////////////////////////////////////
`default_nettype none

package ao_periph_pkg;

  // Register bus word types
  typedef logic [31:0] reg_addr_t;
  typedef logic [31:0] reg_data_t;
  typedef logic [3:0]  reg_strb_t;

  // Decoder result
  typedef enum logic [1:0] {
    SEL_SOC_CTRL,
    SEL_FAST_INTR,
    SEL_GPIO,
    SEL_NONE
  } periph_sel_e;

endpackage : ao_periph_pkg

`default_nettype wire

// ==== logic/reg_bus_if.sv ====
////////////////////////////////////////
// Register bus, one transfer per valid/ready
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if;
  import ao_periph_pkg::*;

  logic      valid;
  logic      write;
  reg_addr_t addr;
  reg_data_t wdata;
  reg_strb_t strb;
  logic      ready;
  reg_data_t rdata;

  modport host (
    output valid, write, addr, wdata, strb,
    input  ready, rdata
  );

  modport device (
    input  valid, write, addr, wdata, strb,
    output ready, rdata
  );

endinterface : reg_bus_if

`default_nettype wire

// ==== logic/obi_to_reg.sv ====
////////////////////////////////////////
// OBI slave to register bus bridge
// One access in flight at a time
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module obi_to_reg (
  input  wire logic                     clk_i,
  input  wire logic                     rst_i,
  input  wire logic                     req_i,
  input  wire logic                     we_i,
  input  wire ao_periph_pkg::reg_addr_t addr_i,
  input  wire ao_periph_pkg::reg_data_t wdata_i,
  input  wire ao_periph_pkg::reg_strb_t be_i,
  output logic                          gnt_o,
  output logic                          rvalid_o,
  output ao_periph_pkg::reg_data_t      rdata_o,
  reg_bus_if.host                       reg_o
);
  import ao_periph_pkg::*;

  typedef enum logic {
    IDLE,
    BUSY
  } state_e;

  state_e    state_q;
  logic      rvalid_q;
  logic      we_q;
  reg_addr_t addr_q;
  reg_data_t wdata_q;
  reg_strb_t be_q;
  reg_data_t rdata_q;
  logic      busy;
  logic      done;

  assign busy = (state_q == BUSY);
  assign done = busy & reg_o.ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= IDLE;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= done;
      case (state_q)
        IDLE: if (req_i) state_q <= BUSY;
        BUSY: if (reg_o.ready) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Request capture and response data
  always_ff @(posedge clk_i) begin
    if (!busy && req_i) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      be_q    <= be_i;
    end
    if (done) begin
      rdata_q <= reg_o.rdata;
    end
  end

  assign reg_o.valid = busy;
  assign reg_o.write = we_q;
  assign reg_o.addr  = addr_q;
  assign reg_o.wdata = wdata_q;
  assign reg_o.strb  = be_q;

  // Grant lands in the cycle the device takes the transfer
  assign gnt_o    = done;
  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule : obi_to_reg

`default_nettype wire

// ==== logic/reg_demux.sv ====
////////////////////////////////////////
// Register bus address decoder and demux
// Unmapped accesses get the error word
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "ao_periph_cfg.svh"

module reg_demux (
  reg_bus_if.device up_i,
  reg_bus_if.host   soc_o,
  reg_bus_if.host   fic_o,
  reg_bus_if.host   gpio_o
);
  import ao_periph_pkg::*;

  periph_sel_e sel;
  reg_addr_t   base;
  reg_addr_t   offset;

  function automatic logic in_region(reg_addr_t addr, reg_addr_t region_base);
    return (addr >= region_base) && (addr < region_base + `AO_REGION_SIZE);
  endfunction

  always_comb begin
    if (in_region(up_i.addr, `AO_SOC_CTRL_BASE)) begin
      sel  = SEL_SOC_CTRL;
      base = `AO_SOC_CTRL_BASE;
    end else if (in_region(up_i.addr, `AO_FAST_INTR_BASE)) begin
      sel  = SEL_FAST_INTR;
      base = `AO_FAST_INTR_BASE;
    end else if (in_region(up_i.addr, `AO_GPIO_BASE)) begin
      sel  = SEL_GPIO;
      base = `AO_GPIO_BASE;
    end else begin
      sel  = SEL_NONE;
      base = '0;
    end
  end

  assign offset = up_i.addr - base;

  // Request fan-out, only the selected device sees valid
  assign soc_o.valid  = up_i.valid && (sel == SEL_SOC_CTRL);
  assign soc_o.write  = up_i.write;
  assign soc_o.addr   = offset;
  assign soc_o.wdata  = up_i.wdata;
  assign soc_o.strb   = up_i.strb;

  assign fic_o.valid  = up_i.valid && (sel == SEL_FAST_INTR);
  assign fic_o.write  = up_i.write;
  assign fic_o.addr   = offset;
  assign fic_o.wdata  = up_i.wdata;
  assign fic_o.strb   = up_i.strb;

  assign gpio_o.valid = up_i.valid && (sel == SEL_GPIO);
  assign gpio_o.write = up_i.write;
  assign gpio_o.addr  = offset;
  assign gpio_o.wdata = up_i.wdata;
  assign gpio_o.strb  = up_i.strb;

  always_comb begin
    case (sel)
      SEL_SOC_CTRL: begin
        up_i.ready = soc_o.ready;
        up_i.rdata = soc_o.rdata;
      end
      SEL_FAST_INTR: begin
        up_i.ready = fic_o.ready;
        up_i.rdata = fic_o.rdata;
      end
      SEL_GPIO: begin
        up_i.ready = gpio_o.ready;
        up_i.rdata = gpio_o.rdata;
      end
      default: begin
        // Error responder
        up_i.ready = up_i.valid;
        up_i.rdata = `AO_ERR_WORD;
      end
    endcase
  end

endmodule : reg_demux

`default_nettype wire

// ==== logic/soc_ctrl.sv ====
////////////////////////////////////////
// SoC control registers
// Exit status, scratch word, boot strap
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "ao_periph_cfg.svh"

module soc_ctrl (
  input  wire logic                clk_i,
  input  wire logic                rst_i,
  reg_bus_if.device                reg_i,
  input  wire logic                boot_select_i,
  output logic                     exit_valid_o,
  output ao_periph_pkg::reg_data_t exit_value_o
);
  import ao_periph_pkg::*;

  logic      exit_valid_q;
  reg_data_t exit_value_q;
  reg_data_t scratch_q;
  logic      wr_en;

  assign wr_en = reg_i.valid & reg_i.write;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      scratch_q    <= '0;
    end else if (wr_en) begin
      if (reg_i.addr == `SOC_EXIT_VALID && reg_i.strb[0]) begin
        exit_valid_q <= reg_i.wdata[0];
      end
      // Byte lanes merge into the old word
      for (int b = 0; b < 4; b++) begin
        if (reg_i.strb[b]) begin
          if (reg_i.addr == `SOC_EXIT_VALUE) begin
            exit_value_q[b*8 +: 8] <= reg_i.wdata[b*8 +: 8];
          end
          if (reg_i.addr == `SOC_SCRATCH) begin
            scratch_q[b*8 +: 8] <= reg_i.wdata[b*8 +: 8];
          end
        end
      end
    end
  end

  always_comb begin
    case (reg_i.addr)
      `SOC_EXIT_VALID: reg_i.rdata = {31'b0, exit_valid_q};
      `SOC_EXIT_VALUE: reg_i.rdata = exit_value_q;
      `SOC_BOOT_SEL:   reg_i.rdata = {31'b0, boot_select_i};
      `SOC_SCRATCH:    reg_i.rdata = scratch_q;
      default:         reg_i.rdata = '0;
    endcase
  end

  assign reg_i.ready  = reg_i.valid;
  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule : soc_ctrl

`default_nettype wire

// ==== logic/fast_intr_ctrl.sv ====
////////////////////////////////////////
// Fast interrupt pending register
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "ao_periph_cfg.svh"

module fast_intr_ctrl (
  input  wire logic                         clk_i,
  input  wire logic                         rst_i,
  reg_bus_if.device                         reg_i,
  input  wire logic [`AO_NUM_FAST_INTR-1:0] fast_intr_i,
  output logic [`AO_NUM_FAST_INTR-1:0]      fast_intr_o
);

  logic [`AO_NUM_FAST_INTR-1:0] pending_q;
  logic [`AO_NUM_FAST_INTR-1:0] clr_mask;
  logic [`AO_NUM_FAST_INTR-1:0] lane_mask;

  // Lines 0..7 live in byte 0, the rest in byte 1
  assign lane_mask = {{(`AO_NUM_FAST_INTR-8){reg_i.strb[1]}}, {8{reg_i.strb[0]}}};

  always_comb begin
    clr_mask = '0;
    if (reg_i.valid && reg_i.write && reg_i.addr == `FIC_CLEAR) begin
      clr_mask = reg_i.wdata[`AO_NUM_FAST_INTR-1:0] & lane_mask;
    end
  end

  // A live input beats a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~clr_mask) | fast_intr_i;
    end
  end

  always_comb begin
    if (reg_i.addr == `FIC_PENDING) begin
      reg_i.rdata = {{(32-`AO_NUM_FAST_INTR){1'b0}}, pending_q};
    end else begin
      reg_i.rdata = '0;
    end
  end

  assign reg_i.ready = reg_i.valid;
  assign fast_intr_o = pending_q;

endmodule : fast_intr_ctrl

`default_nettype wire

// ==== logic/gpio_ao.sv ====
////////////////////////////////////////
// Always-on GPIO
// Pin drive, input sync, edge interrupts
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "ao_periph_cfg.svh"

module gpio_ao (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  reg_bus_if.device                    reg_i,
  input  wire logic [`AO_NUM_GPIO-1:0] cio_gpio_i,
  output logic [`AO_NUM_GPIO-1:0]      cio_gpio_o,
  output logic [`AO_NUM_GPIO-1:0]      cio_gpio_en_o,
  output logic [`AO_NUM_GPIO-1:0]      intr_gpio_o
);

  logic [`AO_NUM_GPIO-1:0] out_q;
  logic [`AO_NUM_GPIO-1:0] en_q;
  logic [`AO_NUM_GPIO-1:0] intr_en_q;
  logic [`AO_NUM_GPIO-1:0] status_q;
  logic [`AO_NUM_GPIO-1:0] sync1_q;
  logic [`AO_NUM_GPIO-1:0] sync2_q;
  logic [`AO_NUM_GPIO-1:0] prev_q;
  logic [`AO_NUM_GPIO-1:0] rise;
  logic [`AO_NUM_GPIO-1:0] clr_mask;
  logic                    wr_en;

  // All pin registers fit in byte lane 0
  assign wr_en = reg_i.valid & reg_i.write & reg_i.strb[0];
  assign rise  = sync2_q & ~prev_q;

  assign clr_mask = (wr_en && reg_i.addr == `GPIO_INTR_STATUS) ?
                    reg_i.wdata[`AO_NUM_GPIO-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync1_q  <= '0;
      sync2_q  <= '0;
      prev_q   <= '0;
      status_q <= '0;
    end else begin
      sync1_q  <= cio_gpio_i;
      sync2_q  <= sync1_q;
      prev_q   <= sync2_q;
      status_q <= (status_q & ~clr_mask) | rise;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_q     <= '0;
      en_q      <= '0;
      intr_en_q <= '0;
    end else if (wr_en) begin
      case (reg_i.addr)
        `GPIO_OUT:     out_q     <= reg_i.wdata[`AO_NUM_GPIO-1:0];
        `GPIO_EN:      en_q      <= reg_i.wdata[`AO_NUM_GPIO-1:0];
        `GPIO_INTR_EN: intr_en_q <= reg_i.wdata[`AO_NUM_GPIO-1:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    reg_i.rdata = '0;
    case (reg_i.addr)
      `GPIO_OUT:         reg_i.rdata[`AO_NUM_GPIO-1:0] = out_q;
      `GPIO_EN:          reg_i.rdata[`AO_NUM_GPIO-1:0] = en_q;
      `GPIO_IN:          reg_i.rdata[`AO_NUM_GPIO-1:0] = sync2_q;
      `GPIO_INTR_EN:     reg_i.rdata[`AO_NUM_GPIO-1:0] = intr_en_q;
      `GPIO_INTR_STATUS: reg_i.rdata[`AO_NUM_GPIO-1:0] = status_q;
      default: ;
    endcase
  end

  assign reg_i.ready   = reg_i.valid;
  assign cio_gpio_o    = out_q;
  assign cio_gpio_en_o = en_q;
  assign intr_gpio_o   = status_q & intr_en_q;

endmodule : gpio_ao

`default_nettype wire

// ==== logic/ao_peripheral_subsystem.sv ====
////////////////////////////////////////
// Always-on peripheral subsystem
// OBI port, register bus, three devices
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "ao_periph_cfg.svh"

module ao_peripheral_subsystem (
  input  wire logic                         clk_i,
  input  wire logic                         rst_i,

  // OBI slave port
  input  wire logic                         slave_req_i,
  input  wire logic                         slave_we_i,
  input  wire ao_periph_pkg::reg_addr_t     slave_addr_i,
  input  wire ao_periph_pkg::reg_data_t     slave_wdata_i,
  input  wire ao_periph_pkg::reg_strb_t     slave_be_i,
  output logic                              slave_gnt_o,
  output logic                              slave_rvalid_o,
  output ao_periph_pkg::reg_data_t          slave_rdata_o,

  // SoC control
  input  wire logic                         boot_select_i,
  output logic                              exit_valid_o,
  output ao_periph_pkg::reg_data_t          exit_value_o,

  // Fast interrupts
  input  wire logic [`AO_NUM_FAST_INTR-1:0] fast_intr_i,
  output logic [`AO_NUM_FAST_INTR-1:0]      fast_intr_o,

  // GPIO
  input  wire logic [`AO_NUM_GPIO-1:0]      cio_gpio_i,
  output logic [`AO_NUM_GPIO-1:0]           cio_gpio_o,
  output logic [`AO_NUM_GPIO-1:0]           cio_gpio_en_o,
  output logic [`AO_NUM_GPIO-1:0]           intr_gpio_o
);

  reg_bus_if reg_up ();
  reg_bus_if reg_soc ();
  reg_bus_if reg_fic ();
  reg_bus_if reg_gpio ();

  obi_to_reg obi_to_reg_i (
    .clk_i,
    .rst_i,
    .req_i    (slave_req_i),
    .we_i     (slave_we_i),
    .addr_i   (slave_addr_i),
    .wdata_i  (slave_wdata_i),
    .be_i     (slave_be_i),
    .gnt_o    (slave_gnt_o),
    .rvalid_o (slave_rvalid_o),
    .rdata_o  (slave_rdata_o),
    .reg_o    (reg_up.host)
  );

  reg_demux reg_demux_i (
    .up_i   (reg_up.device),
    .soc_o  (reg_soc.host),
    .fic_o  (reg_fic.host),
    .gpio_o (reg_gpio.host)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .rst_i,
    .reg_i (reg_soc.device),
    .boot_select_i,
    .exit_valid_o,
    .exit_value_o
  );

  fast_intr_ctrl fast_intr_ctrl_i (
    .clk_i,
    .rst_i,
    .reg_i (reg_fic.device),
    .fast_intr_i,
    .fast_intr_o
  );

  gpio_ao gpio_ao_i (
    .clk_i,
    .rst_i,
    .reg_i (reg_gpio.device),
    .cio_gpio_i,
    .cio_gpio_o,
    .cio_gpio_en_o,
    .intr_gpio_o
  );

endmodule : ao_peripheral_subsystem

`default_nettype wire

// ==== sim/tb_ao_peripheral_subsystem.sv ====
////////////////////////////////////////
// Testbench for the always-on subsystem
// Table-driven OBI accesses with checks
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "ao_periph_cfg.svh"

module tb_ao_peripheral_subsystem;
  import ao_periph_pkg::*;

  localparam int        NUM_ENTRIES  = 35;
  localparam int        RESET_CYCLES = 4;
  localparam int        CYCLE_LIMIT  = 20 * NUM_ENTRIES + RESET_CYCLES;
  localparam logic      RD           = 1'b0;
  localparam logic      WR           = 1'b1;
  localparam reg_addr_t SOC          = `AO_SOC_CTRL_BASE;
  localparam reg_addr_t FIC          = `AO_FAST_INTR_BASE;
  localparam reg_addr_t GPIO         = `AO_GPIO_BASE;

  logic                         clk_i = 1'b0;
  logic                         rst_i;
  logic                         slave_req_i;
  logic                         slave_we_i;
  reg_addr_t                    slave_addr_i;
  reg_data_t                    slave_wdata_i;
  reg_strb_t                    slave_be_i;
  logic                         slave_gnt_o;
  logic                         slave_rvalid_o;
  reg_data_t                    slave_rdata_o;
  logic                         boot_select_i;
  logic                         exit_valid_o;
  reg_data_t                    exit_value_o;
  logic [`AO_NUM_FAST_INTR-1:0] fast_intr_i;
  logic [`AO_NUM_FAST_INTR-1:0] fast_intr_o;
  logic [`AO_NUM_GPIO-1:0]      cio_gpio_i;
  logic [`AO_NUM_GPIO-1:0]      cio_gpio_o;
  logic [`AO_NUM_GPIO-1:0]      cio_gpio_en_o;
  logic [`AO_NUM_GPIO-1:0]      intr_gpio_o;

  // Stimulus and expected values, one column per array
  logic                         t_write      [NUM_ENTRIES];
  reg_addr_t                    t_addr       [NUM_ENTRIES];
  reg_data_t                    t_wdata      [NUM_ENTRIES];
  reg_strb_t                    t_be         [NUM_ENTRIES];
  logic                         t_boot       [NUM_ENTRIES];
  logic [`AO_NUM_FAST_INTR-1:0] t_fast       [NUM_ENTRIES];
  logic [`AO_NUM_GPIO-1:0]      t_pins       [NUM_ENTRIES];
  reg_data_t                    t_rdata      [NUM_ENTRIES];
  logic                         t_exit_valid [NUM_ENTRIES];
  reg_data_t                    t_exit_value [NUM_ENTRIES];
  logic [`AO_NUM_FAST_INTR-1:0] t_fast_o     [NUM_ENTRIES];
  logic [`AO_NUM_GPIO-1:0]      t_gpio_o     [NUM_ENTRIES];
  logic [`AO_NUM_GPIO-1:0]      t_gpio_en    [NUM_ENTRIES];
  logic [`AO_NUM_GPIO-1:0]      t_intr       [NUM_ENTRIES];

  int          n_entries = 0;
  int          cycle_cnt = 0;
  logic [31:0] lfsr_q;

  ao_peripheral_subsystem ao_peripheral_subsystem_i (.*);

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $fatal(1, "cycle limit reached");
    end
  end

  // Galois form, polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end else begin
      return state >> 1;
    end
  endfunction

  task automatic take_bit(output logic b);
    b      = lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("Fail at %0t: %s expected %h, got %h", $time, sig, expected, actual);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_value(input string sig, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else report_mismatch(sig, expected, actual);
  endtask

  task automatic add_entry(input logic wr, input reg_addr_t addr, input reg_data_t wdata,
                           input reg_strb_t be, input logic boot,
                           input logic [`AO_NUM_FAST_INTR-1:0] fast,
                           input logic [`AO_NUM_GPIO-1:0] pins, input reg_data_t rdata,
                           input logic xv, input reg_data_t xval,
                           input logic [`AO_NUM_FAST_INTR-1:0] fast_o,
                           input logic [`AO_NUM_GPIO-1:0] gpio_o,
                           input logic [`AO_NUM_GPIO-1:0] gpio_en,
                           input logic [`AO_NUM_GPIO-1:0] intr);
    t_write[n_entries]      = wr;
    t_addr[n_entries]       = addr;
    t_wdata[n_entries]      = wdata;
    t_be[n_entries]         = be;
    t_boot[n_entries]       = boot;
    t_fast[n_entries]       = fast;
    t_pins[n_entries]       = pins;
    t_rdata[n_entries]      = rdata;
    t_exit_valid[n_entries] = xv;
    t_exit_value[n_entries] = xval;
    t_fast_o[n_entries]     = fast_o;
    t_gpio_o[n_entries]     = gpio_o;
    t_gpio_en[n_entries]    = gpio_en;
    t_intr[n_entries]       = intr;
    n_entries++;
  endtask

  // Side outputs are checked in the response cycle
  task automatic fill_table();
    // Reset state and SoC control
    add_entry(RD, SOC + `SOC_SCRATCH, 0, 4'h0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_entry(WR, SOC + `SOC_EXIT_VALUE, 32'h1234_5678, 4'hf, 0, 0, 0,
              0, 0, 32'h1234_5678, 0, 0, 0, 0);
    add_entry(WR, SOC + `SOC_EXIT_VALID, 1, 4'h1, 0, 0, 0, 0, 1, 32'h1234_5678, 0, 0, 0, 0);
    add_entry(RD, SOC + `SOC_EXIT_VALUE, 0, 4'h0, 0, 0, 0,
              32'h1234_5678, 1, 32'h1234_5678, 0, 0, 0, 0);
    add_entry(RD, SOC + `SOC_BOOT_SEL, 0, 4'h0, 1, 0, 0, 1, 1, 32'h1234_5678, 0, 0, 0, 0);
    add_entry(RD, SOC + `SOC_BOOT_SEL, 0, 4'h0, 0, 0, 0, 0, 1, 32'h1234_5678, 0, 0, 0, 0);
    // Scratch byte lanes
    add_entry(WR, SOC + `SOC_SCRATCH, 32'ha5a5_a5a5, 4'hf, 0, 0, 0,
              0, 1, 32'h1234_5678, 0, 0, 0, 0);
    add_entry(WR, SOC + `SOC_SCRATCH, 32'h1122_3344, 4'h5, 0, 0, 0,
              0, 1, 32'h1234_5678, 0, 0, 0, 0);
    add_entry(RD, SOC + `SOC_SCRATCH, 0, 4'h0, 0, 0, 0,
              32'ha522_a544, 1, 32'h1234_5678, 0, 0, 0, 0);
    add_entry(WR, SOC + `SOC_SCRATCH, 32'hffee_ddcc, 4'h8, 0, 0, 0,
              0, 1, 32'h1234_5678, 0, 0, 0, 0);
    add_entry(RD, SOC + `SOC_SCRATCH, 0, 4'h0, 0, 0, 0,
              32'hff22_a544, 1, 32'h1234_5678, 0, 0, 0, 0);
    // Fast interrupts, set, clear, clear against a held line
    add_entry(RD, FIC + `FIC_PENDING, 0, 4'h0, 0, 15'h0013, 0,
              32'h0013, 1, 32'h1234_5678, 15'h0013, 0, 0, 0);
    add_entry(RD, FIC + `FIC_PENDING, 0, 4'h0, 0, 15'h4100, 0,
              32'h4113, 1, 32'h1234_5678, 15'h4113, 0, 0, 0);
    add_entry(WR, FIC + `FIC_CLEAR, 32'h0011, 4'h3, 0, 0, 0,
              0, 1, 32'h1234_5678, 15'h4102, 0, 0, 0);
    add_entry(RD, FIC + `FIC_PENDING, 0, 4'h0, 0, 0, 0,
              32'h4102, 1, 32'h1234_5678, 15'h4102, 0, 0, 0);
    add_entry(WR, FIC + `FIC_CLEAR, 32'h4100, 4'h3, 0, 15'h4000, 0,
              0, 1, 32'h1234_5678, 15'h4002, 0, 0, 0);
    add_entry(RD, FIC + `FIC_PENDING, 0, 4'h0, 0, 0, 0,
              32'h4002, 1, 32'h1234_5678, 15'h4002, 0, 0, 0);
    add_entry(WR, FIC + `FIC_CLEAR, 32'h4002, 4'h3, 0, 0, 0, 0, 1, 32'h1234_5678, 0, 0, 0, 0);
    // GPIO drive and enables
    add_entry(WR, GPIO + `GPIO_OUT, 32'h5a, 4'h1, 0, 0, 0, 0, 1, 32'h1234_5678, 0, 8'h5a, 0, 0);
    add_entry(WR, GPIO + `GPIO_EN, 32'hf0, 4'h1, 0, 0, 0,
              0, 1, 32'h1234_5678, 0, 8'h5a, 8'hf0, 0);
    add_entry(WR, GPIO + `GPIO_INTR_EN, 32'h0f, 4'h1, 0, 0, 0,
              0, 1, 32'h1234_5678, 0, 8'h5a, 8'hf0, 0);
    // Edges on pin 0 (enabled) and pin 7 (disabled)
    add_entry(RD, GPIO + `GPIO_INTR_EN, 0, 4'h0, 0, 0, 8'h81,
              32'h0f, 1, 32'h1234_5678, 0, 8'h5a, 8'hf0, 0);
    add_entry(RD, GPIO + `GPIO_IN, 0, 4'h0, 0, 0, 8'h81,
              32'h81, 1, 32'h1234_5678, 0, 8'h5a, 8'hf0, 8'h01);
    add_entry(RD, GPIO + `GPIO_INTR_STATUS, 0, 4'h0, 0, 0, 8'h81,
              32'h81, 1, 32'h1234_5678, 0, 8'h5a, 8'hf0, 8'h01);
    add_entry(WR, GPIO + `GPIO_INTR_STATUS, 32'h01, 4'h1, 0, 0, 8'h81,
              0, 1, 32'h1234_5678, 0, 8'h5a, 8'hf0, 0);
    add_entry(RD, GPIO + `GPIO_INTR_STATUS, 0, 4'h0, 0, 0, 8'h81,
              32'h80, 1, 32'h1234_5678, 0, 8'h5a, 8'hf0, 0);
    add_entry(WR, GPIO + `GPIO_OUT, 32'ha5, 4'h1, 0, 0, 0,
              0, 1, 32'h1234_5678, 0, 8'ha5, 8'hf0, 0);
    add_entry(RD, GPIO + `GPIO_IN, 0, 4'h0, 0, 0, 0, 0, 1, 32'h1234_5678, 0, 8'ha5, 8'hf0, 0);
    add_entry(RD, GPIO + `GPIO_OUT, 0, 4'h0, 0, 0, 8'h02,
              32'ha5, 1, 32'h1234_5678, 0, 8'ha5, 8'hf0, 0);
    add_entry(RD, GPIO + `GPIO_INTR_STATUS, 0, 4'h0, 0, 0, 8'h02,
              32'h82, 1, 32'h1234_5678, 0, 8'ha5, 8'hf0, 8'h02);
    add_entry(WR, GPIO + `GPIO_INTR_STATUS, 32'h82, 4'h1, 0, 0, 8'h02,
              0, 1, 32'h1234_5678, 0, 8'ha5, 8'hf0, 0);
    // Unmapped region
    add_entry(RD, 32'h0000_3000, 0, 4'h0, 0, 0, 8'h02,
              32'hbadc_ab1e, 1, 32'h1234_5678, 0, 8'ha5, 8'hf0, 0);
    add_entry(WR, 32'h0000_300c, 32'hdead_beef, 4'hf, 0, 0, 8'h02,
              0, 1, 32'h1234_5678, 0, 8'ha5, 8'hf0, 0);
    add_entry(RD, SOC + `SOC_SCRATCH, 0, 4'h0, 0, 0, 8'h02,
              32'hff22_a544, 1, 32'h1234_5678, 0, 8'ha5, 8'hf0, 0);
    add_entry(RD, SOC + `SOC_EXIT_VALUE, 0, 4'h0, 0, 0, 8'h02,
              32'h1234_5678, 1, 32'h1234_5678, 0, 8'ha5, 8'hf0, 0);
  endtask

  task automatic check_side(input int idx);
    check_value("exit_valid_o", t_exit_valid[idx], exit_valid_o);
    check_value("exit_value_o", t_exit_value[idx], exit_value_o);
    check_value("fast_intr_o", t_fast_o[idx], fast_intr_o);
    check_value("cio_gpio_o", t_gpio_o[idx], cio_gpio_o);
    check_value("cio_gpio_en_o", t_gpio_en[idx], cio_gpio_en_o);
    check_value("intr_gpio_o", t_intr[idx], intr_gpio_o);
  endtask

  task automatic run_entry(input int idx);
    int         waited;
    logic [1:0] gap;
    waited = 0;
    @(posedge clk_i);
    slave_req_i   <= 1'b1;
    slave_we_i    <= t_write[idx];
    slave_addr_i  <= t_addr[idx];
    slave_wdata_i <= t_wdata[idx];
    slave_be_i    <= t_be[idx];
    boot_select_i <= t_boot[idx];
    fast_intr_i   <= t_fast[idx];
    cio_gpio_i    <= t_pins[idx];
    // Hold the request until the grant shows up
    do begin
      @(negedge clk_i);
      waited++;
      check_value("slave_rvalid_o", 0, slave_rvalid_o);
    end while (!slave_gnt_o);
    check_value("slave_gnt_o latency", 2, waited);
    @(posedge clk_i);
    slave_req_i <= 1'b0;
    @(negedge clk_i);
    check_value("slave_rvalid_o", 1, slave_rvalid_o);
    check_value("slave_gnt_o", 0, slave_gnt_o);
    if (!t_write[idx]) begin
      check_value("slave_rdata_o", t_rdata[idx], slave_rdata_o);
    end
    check_side(idx);
    take_bit(gap[0]);
    take_bit(gap[1]);
    repeat (gap) @(posedge clk_i);
  endtask

  initial begin
    rst_i         = 1'b1;
    slave_req_i   = 1'b0;
    slave_we_i    = 1'b0;
    slave_addr_i  = '0;
    slave_wdata_i = '0;
    slave_be_i    = '0;
    boot_select_i = 1'b0;
    fast_intr_i   = '0;
    cio_gpio_i    = '0;
    lfsr_q        = 32'hd55a_3c7f;
    fill_table();
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check_value("slave_gnt_o", 0, slave_gnt_o);
    check_value("slave_rvalid_o", 0, slave_rvalid_o);
    check_value("exit_valid_o", 0, exit_valid_o);
    check_value("exit_value_o", 0, exit_value_o);
    check_value("fast_intr_o", 0, fast_intr_o);
    check_value("cio_gpio_o", 0, cio_gpio_o);
    check_value("cio_gpio_en_o", 0, cio_gpio_en_o);
    check_value("intr_gpio_o", 0, intr_gpio_o);
    for (int i = 0; i < n_entries; i++) begin
      run_entry(i);
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule : tb_ao_peripheral_subsystem

`default_nettype wire

// ==== verilog.f ====
+incdir+logic
logic/ao_periph_pkg.sv
logic/reg_bus_if.sv
logic/obi_to_reg.sv
logic/reg_demux.sv
logic/soc_ctrl.sv
logic/fast_intr_ctrl.sv
logic/gpio_ao.sv
logic/ao_peripheral_subsystem.sv
sim/tb_ao_peripheral_subsystem.sv
